// File: Makefile
OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_mem_subsys -Mdir $(OBJ_DIR) -o sim

run: compile
	./$(OBJ_DIR)/sim > sim.log 2>&1; cat sim.log
	@if grep -q "Test failed" sim.log; then echo "simulation FAILED"; exit 1; fi
	@grep -q "Test completed successfully" sim.log || (echo "simulation ended without result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) sim.log

// File: sources.f
verilog/mem_pkg.sv
verilog/exmem_reg.sv
verilog/lsu_ext.sv
verilog/mem_stage.sv
verilog/dmem_sram.sv
verilog/memwb_reg.sv
verilog/mem_subsys_top.sv
testbench/mem_checker.sv
testbench/tb_mem_subsys.sv

// File: testbench/mem_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mem_checker (
  input  wire             clk,
  input  wire             reset_i,
  input  wire             ex_valid_i,
  input  mem_pkg::exmem_t ex_bundle_i,
  input  wire             stall_i,
  input  wire             wb_valid_i,
  input  mem_pkg::memwb_t wb_bundle_i,
  output int              errors_o,
  output int              checked_o,
  output int              pending_o
);

  logic [7:0]      ref_mem [mem_pkg::DMEM_WORDS*4];  // byte image
  mem_pkg::memwb_t exp_q [$];
  int              lat_q [$];  // expected latency per instr
  int              acc_q [$];  // cycle of acceptance
  int              cycle     = 0;
  int              err_cnt   = 0;
  int              chk_cnt   = 0;
  int              pend_cnt  = 0;
  int              busy_left = 0;  // stall cycles still expected

  assign errors_o  = err_cnt;
  assign checked_o = chk_cnt;
  assign pending_o = pend_cnt;

  task automatic check_val(input string name, input logic [31:0] exp_v, input logic [31:0] got_v);
    if (got_v !== exp_v) begin
      $display("ERR %s exp=%h got=%h (cycle %0d)", name, exp_v, got_v, cycle);
      err_cnt++;
    end
  endtask

  // expected writeback by rv32i load/store rules and ref_mem update
  task automatic predict(input mem_pkg::exmem_t b, output mem_pkg::memwb_t w, output int lat);
    int          nbytes;
    int          a;
    logic        load;
    logic        store;
    logic        sgn;
    logic        mis;
    logic [31:0] v;
    load  = b.mem_op inside {mem_pkg::MEMOP_LB, mem_pkg::MEMOP_LBU, mem_pkg::MEMOP_LH,
                             mem_pkg::MEMOP_LHU, mem_pkg::MEMOP_LW};
    store = b.mem_op inside {mem_pkg::MEMOP_SB, mem_pkg::MEMOP_SH, mem_pkg::MEMOP_SW};
    sgn   = b.mem_op inside {mem_pkg::MEMOP_LB, mem_pkg::MEMOP_LH};
    if (b.mem_op inside {mem_pkg::MEMOP_LB, mem_pkg::MEMOP_LBU, mem_pkg::MEMOP_SB}) begin
      nbytes = 1;
    end else if (b.mem_op inside {mem_pkg::MEMOP_LH, mem_pkg::MEMOP_LHU, mem_pkg::MEMOP_SH}) begin
      nbytes = 2;
    end else begin
      nbytes = 4;
    end
    a   = int'(b.alu_data[9:0]);
    mis = (load | store) && (a % nbytes != 0);  // natural alignment
    lat = ((load | store) && !mis) ? mem_pkg::DMEM_WAIT + 1 : 1;
    v   = '0;  // stores and misaligned give 0
    if (!(load | store)) begin
      v = b.alu_data;
    end else if (!mis) begin
      for (int k = 0; k < nbytes; k++) begin
        if (store) begin
          ref_mem[a+k] = b.rs2_data[8*k +: 8];  // little endian
        end else begin
          v[8*k +: 8] = ref_mem[a+k];
        end
      end
      if (load && sgn && v[8*nbytes-1]) begin
        v = v | (32'hffff_ffff << (8 * nbytes));
      end
    end
    w.inst_addr = b.inst_addr;
    w.inst_data = b.inst_data;
    w.rd_idx    = b.rd_idx;
    w.mem_data  = v;
    w.trap      = b.trap;
    if (mis) begin
      w.trap[mem_pkg::TRAP_MISALIGN] = 1'b1;
    end
  endtask

  task automatic compare_wb;
    mem_pkg::memwb_t exp_wb;
    int              lat;
    int              acc;
    if (exp_q.size() == 0) begin
      $display("writeback at cycle %0d with no instruction outstanding", cycle);
      err_cnt++;
    end else begin
      exp_wb = exp_q.pop_front();
      lat    = lat_q.pop_front();
      acc    = acc_q.pop_front();
      check_val("inst_addr", exp_wb.inst_addr, wb_bundle_i.inst_addr);
      check_val("inst_data", exp_wb.inst_data, wb_bundle_i.inst_data);
      check_val("rd_idx", 32'(exp_wb.rd_idx), 32'(wb_bundle_i.rd_idx));
      check_val("mem_data", exp_wb.mem_data, wb_bundle_i.mem_data);
      check_val("trap", 32'(exp_wb.trap), 32'(wb_bundle_i.trap));
      check_val("latency", 32'(lat), 32'(cycle - acc - 1));  // edges after capture
      chk_cnt++;
    end
  endtask

  always @(posedge clk) begin
    mem_pkg::memwb_t pred;
    int              lat;
    cycle = cycle + 1;
    if (!reset_i) begin
      // stall high while an aligned access waits for ready
      check_val("stall_o", 32'(busy_left != 0), 32'(stall_i));
      if (busy_left > 0) begin
        busy_left--;
      end
      if (wb_valid_i) begin
        compare_wb();
      end
      // taken when offered with the stage free
      if (ex_valid_i && !stall_i) begin
        predict(ex_bundle_i, pred, lat);
        exp_q.push_back(pred);
        lat_q.push_back(lat);
        acc_q.push_back(cycle);
        busy_left = lat - 1;
      end
    end
    pend_cnt = exp_q.size();
  end

endmodule

`default_nettype wire

// File: testbench/mem_patterns.hex
// op word (bits 3:0 mem_op, bits 15:8 incoming trap), address, store data, alu data, rd
// address is used as alu_data for loads and stores, the alu column otherwise
00000000 00000000 00000000 12345678 01
00000008 00000040 8899aabb 00000000 02
00000006 00000041 aabbcc71 00000000 03
00000007 00000042 5566c3d4 00000000 04
00000001 00000040 00000000 00000000 05
00000001 00000041 00000000 00000000 06
00000001 00000042 00000000 00000000 07
00000001 00000043 00000000 00000000 08
00000002 00000040 00000000 00000000 09
00000002 00000041 00000000 00000000 0a
00000002 00000042 00000000 00000000 0b
00000002 00000043 00000000 00000000 0c
00000003 00000040 00000000 00000000 0d
00000003 00000042 00000000 00000000 0e
00000004 00000040 00000000 00000000 0f
00000004 00000042 00000000 00000000 10
00000003 00000043 00000000 00000000 11
00008005 00000041 00000000 00000000 12
00000007 00000041 0000ffff 00000000 13
00000008 00000042 ffffffff 00000000 14
00000005 00000040 00000000 00000000 15
00004000 00000000 00000000 cafef00d 1f

// File: testbench/tb_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys;

  localparam int N_ENTRIES      = 22;
  localparam int N_COLS         = 5;  // words per pattern entry
  localparam int RESET_CYCLES   = 10;
  localparam int MAX_IDLE       = 3;  // most idle cycles before an entry
  localparam int TIMEOUT_CYCLES = N_ENTRIES * (mem_pkg::DMEM_WAIT + 4)
                                + RESET_CYCLES + N_ENTRIES * MAX_IDLE + 8;

  logic            clk;
  logic            reset_i;
  logic            ex_valid_i;
  mem_pkg::exmem_t ex_bundle_i;
  logic            stall_o;
  logic            wb_valid_o;
  mem_pkg::memwb_t wb_bundle_o;

  logic [31:0] pat [N_ENTRIES*N_COLS];  // flat pattern words
  integer      seed;
  int          cycle_cnt;
  int          err_cnt;
  int          chk_cnt;
  int          pend_cnt;

  mem_subsys_top i_dut (
    .clk         (clk),
    .reset_i     (reset_i),
    .ex_valid_i  (ex_valid_i),
    .ex_bundle_i (ex_bundle_i),
    .stall_o     (stall_o),
    .wb_valid_o  (wb_valid_o),
    .wb_bundle_o (wb_bundle_o)
  );

  mem_checker i_checker (
    .clk         (clk),
    .reset_i     (reset_i),
    .ex_valid_i  (ex_valid_i),
    .ex_bundle_i (ex_bundle_i),
    .stall_i     (stall_o),
    .wb_valid_i  (wb_valid_o),
    .wb_bundle_i (wb_bundle_o),
    .errors_o    (err_cnt),
    .checked_o   (chk_cnt),
    .pending_o   (pend_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  // one execute bundle from its pattern words
  function automatic mem_pkg::exmem_t make_bundle(input int idx);
    mem_pkg::exmem_t b;
    logic [31:0]     opw;
    opw         = pat[idx*N_COLS];
    b.inst_addr = 32'h0000_1000 + 32'(idx * 4);
    b.inst_data = '0;
    b.rd_idx    = pat[idx*N_COLS+4][4:0];
    b.rs2_data  = pat[idx*N_COLS+2];
    b.mem_op    = mem_pkg::memop_e'(opw[3:0]);
    b.trap      = opw[15:8];  // incoming trap bits
    // address column feeds alu_data for loads and stores
    b.alu_data  = (b.mem_op == mem_pkg::MEMOP_NONE) ? pat[idx*N_COLS+3] : pat[idx*N_COLS+1];
    return b;
  endfunction

  // run limit
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("errors: %0d  checked: %0d  outstanding: %0d", err_cnt, chk_cnt, pend_cnt);
    $display("Test failed");
    $finish;
  end

  initial begin
    int idle;
    int i;
    seed        = 32'h8eb88384;
    reset_i     = 1'b1;
    ex_valid_i  = 1'b0;
    ex_bundle_i = '0;
    $readmemh("testbench/mem_patterns.hex", pat);
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset_i = 1'b0;
    for (i = 0; i < N_ENTRIES; i++) begin
      idle = int'($unsigned($random(seed)) % (MAX_IDLE + 1));
      repeat (idle) begin
        ex_valid_i = 1'b0;
        @(negedge clk);
      end
      ex_valid_i            = 1'b1;
      ex_bundle_i           = make_bundle(i);
      ex_bundle_i.inst_data = $random(seed);
      while (stall_o) @(negedge clk);  // held while the stage is busy
      @(negedge clk);  // taken at the edge just passed
    end
    ex_valid_i = 1'b0;
    while (pend_cnt != 0) @(negedge clk);
    repeat (4) @(negedge clk);  // room for stray writebacks
    $display("errors: %0d  checked: %0d  outstanding: %0d", err_cnt, chk_cnt, pend_cnt);
    if (err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/dmem_sram.sv
`timescale 1ns/1ps
`default_nettype none

module dmem_sram (
  input  wire                clk,
  input  wire                reset_i,
  input  mem_pkg::dmem_req_t req_i,
  output logic               ready_o,
  output mem_pkg::xlen_t     rdata_o
);

  mem_pkg::xlen_t                mem_q [mem_pkg::DMEM_WORDS];
  mem_pkg::wait_cnt_t            wait_cnt_q;
  logic [mem_pkg::DMEM_AW-1:0]   word_idx;

  // addr bits 9:2
  assign word_idx = req_i.addr[mem_pkg::DMEM_AW+1:2];

  // ready straight off the counter, no path from addr_valid
  assign ready_o = (wait_cnt_q == mem_pkg::wait_cnt_t'(mem_pkg::DMEM_WAIT));

  // counts consecutive request cycles
  always_ff @(posedge clk) begin
    if (reset_i) begin
      wait_cnt_q <= '0;
    end else if (ready_o) begin
      wait_cnt_q <= '0;  // clear on the pulse
    end else if (req_i.addr_valid) begin
      wait_cnt_q <= wait_cnt_q + 1'b1;
    end else begin
      wait_cnt_q <= '0;  // request dropped, restart
    end
  end

  // byte masked write in the ready cycle
  always_ff @(posedge clk) begin
    if (ready_o && req_i.write_valid) begin
      for (int b = 0; b < mem_pkg::NBYTES; b++) begin
        if (req_i.mask[b]) begin
          mem_q[word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // whole word out during ready only
  assign rdata_o = ready_o ? mem_q[word_idx] : '0;

endmodule

`default_nettype wire

// File: verilog/exmem_reg.sv
`timescale 1ns/1ps
`default_nettype none

module exmem_reg (
  input  wire             clk,
  input  wire             reset_i,
  input  wire             stall_i,   // memory stage busy
  input  wire             valid_i,
  input  mem_pkg::exmem_t bundle_i,
  output logic            valid_o,
  output mem_pkg::exmem_t bundle_o
);

  logic            valid_q;
  mem_pkg::exmem_t bundle_q;

  // advance only when the stage below is free
  logic load_en;
  assign load_en = ~stall_i;

  // valid cleared on reset
  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else if (load_en) begin
      valid_q <= valid_i;  // bubble if nothing offered
    end
  end

  // payload follows valid
  // held stable for the whole access so addr_valid stays a clean level
  always_ff @(posedge clk) begin
    if (load_en) begin
      bundle_q <= bundle_i;
    end
  end

  assign valid_o  = valid_q;
  assign bundle_o = bundle_q;

endmodule

`default_nettype wire

// File: verilog/lsu_ext.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_ext (
  input  mem_pkg::xlen_t    data_i,    // raw word from memory
  input  wire [1:0]         offset_i,  // byte offset in word
  input  mem_pkg::size_oh_t size_i,
  input  wire               signed_i,  // 1 sign extend, 0 zero extend
  output mem_pkg::xlen_t    data_o
);

  mem_pkg::xlen_t lane;
  logic           sign_b;
  logic           sign_h;

  // bring addressed lane down to bit 0
  assign lane = data_i >> {offset_i, 3'b000};

  assign sign_b = signed_i & lane[7];
  assign sign_h = signed_i & lane[15];

  always_comb begin
    case (size_i)
      mem_pkg::SIZE_BYTE: data_o = {{24{sign_b}}, lane[7:0]};
      mem_pkg::SIZE_HALF: data_o = {{16{sign_h}}, lane[15:0]};
      mem_pkg::SIZE_WORD: data_o = lane;  // offset is 0 when aligned
      default:            data_o = '0;    // non-load
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/mem_pkg.sv
`default_nettype none

package mem_pkg;

  // base widths
  localparam int XLEN      = 32;
  localparam int NBYTES    = XLEN / 8;  // byte lanes per word
  localparam int REG_IDX_W = 5;
  localparam int TRAP_W    = 8;

  // trap bus bit assignment, other bits pass through
  localparam int TRAP_MISALIGN = 0;

  // data memory geometry and response wait
  localparam int DMEM_WORDS = 256;
  localparam int DMEM_AW    = $clog2(DMEM_WORDS);  // word index bits
  localparam int DMEM_WAIT  = 2;  // cycles held before ready
  localparam int WAIT_CNT_W = $clog2(DMEM_WAIT + 1);

  typedef logic [XLEN-1:0]       xlen_t;
  typedef logic [REG_IDX_W-1:0]  reg_idx_t;
  typedef logic [NBYTES-1:0]     byte_mask_t;
  typedef logic [TRAP_W-1:0]     trap_t;
  typedef logic [WAIT_CNT_W-1:0] wait_cnt_t;
  typedef logic [2:0]            size_oh_t;  // one-hot {word, half, byte}

  // access size encodings
  localparam size_oh_t SIZE_BYTE = 3'b001;
  localparam size_oh_t SIZE_HALF = 3'b010;
  localparam size_oh_t SIZE_WORD = 3'b100;

  // memory opcode from execute
  typedef enum logic [3:0] {
    MEMOP_NONE = 4'd0,
    MEMOP_LB   = 4'd1,
    MEMOP_LBU  = 4'd2,
    MEMOP_LH   = 4'd3,
    MEMOP_LHU  = 4'd4,
    MEMOP_LW   = 4'd5,
    MEMOP_SB   = 4'd6,
    MEMOP_SH   = 4'd7,
    MEMOP_SW   = 4'd8
  } memop_e;

  // execute -> memory bundle
  typedef struct packed {
    xlen_t    inst_addr;
    xlen_t    inst_data;
    reg_idx_t rd_idx;
    xlen_t    rs2_data;   // store source
    memop_e   mem_op;
    xlen_t    alu_data;   // address or result
    trap_t    trap;
  } exmem_t;

  // memory -> writeback bundle
  typedef struct packed {
    xlen_t    inst_addr;
    xlen_t    inst_data;
    reg_idx_t rd_idx;
    xlen_t    mem_data;
    trap_t    trap;
  } memwb_t;

  // dcache style request
  typedef struct packed {
    xlen_t      addr;         // word aligned
    logic       addr_valid;   // level, held until ready
    logic       write_valid;  // store
    byte_mask_t mask;
    size_oh_t   size;
    xlen_t      wdata;        // already lane shifted
  } dmem_req_t;

endpackage

`default_nettype wire

// File: verilog/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
  input  wire                valid_i,
  input  mem_pkg::exmem_t    bundle_i,
  input  wire                ready_i,   // one cycle pulse from memory
  input  mem_pkg::xlen_t     rdata_i,
  output mem_pkg::dmem_req_t req_o,
  output logic               stall_o,
  output mem_pkg::memwb_t    wb_o
);

  logic                 is_load;
  logic                 is_store;
  logic                 is_signed;
  mem_pkg::size_oh_t    size;
  logic [1:0]           offset;
  logic                 misalign;
  logic                 req_ok;
  mem_pkg::byte_mask_t  base_mask;
  mem_pkg::xlen_t       store_data;
  mem_pkg::xlen_t       load_data;
  mem_pkg::xlen_t       mem_data;
  mem_pkg::trap_t       misalign_trap;

  // opcode decode
  assign is_load   = bundle_i.mem_op inside {mem_pkg::MEMOP_LB, mem_pkg::MEMOP_LBU,
                                             mem_pkg::MEMOP_LH, mem_pkg::MEMOP_LHU,
                                             mem_pkg::MEMOP_LW};
  assign is_store  = bundle_i.mem_op inside {mem_pkg::MEMOP_SB, mem_pkg::MEMOP_SH,
                                             mem_pkg::MEMOP_SW};
  assign is_signed = bundle_i.mem_op inside {mem_pkg::MEMOP_LB, mem_pkg::MEMOP_LH};

  // access size per opcode
  always_comb begin
    case (bundle_i.mem_op)
      mem_pkg::MEMOP_LB, mem_pkg::MEMOP_LBU, mem_pkg::MEMOP_SB: size = mem_pkg::SIZE_BYTE;
      mem_pkg::MEMOP_LH, mem_pkg::MEMOP_LHU, mem_pkg::MEMOP_SH: size = mem_pkg::SIZE_HALF;
      mem_pkg::MEMOP_LW, mem_pkg::MEMOP_SW:                     size = mem_pkg::SIZE_WORD;
      default:                                                  size = '0;  // MEMOP_NONE
    endcase
  end

  assign offset = bundle_i.alu_data[1:0];

  // half needs an even addr and word a multiple of 4
  assign misalign = (size[1] & offset[0]) | (size[2] & (|offset));

  // request only for valid aligned accesses
  assign req_ok = valid_i & (is_load | is_store) & ~misalign;

  // size mask before lane shift
  always_comb begin
    case (size)
      mem_pkg::SIZE_BYTE: base_mask = 4'b0001;
      mem_pkg::SIZE_HALF: base_mask = 4'b0011;
      mem_pkg::SIZE_WORD: base_mask = 4'b1111;
      default:            base_mask = 4'b0000;
    endcase
  end

  // trim store source to its size
  always_comb begin
    case (size)
      mem_pkg::SIZE_BYTE: store_data = {24'b0, bundle_i.rs2_data[7:0]};
      mem_pkg::SIZE_HALF: store_data = {16'b0, bundle_i.rs2_data[15:0]};
      default:            store_data = bundle_i.rs2_data;
    endcase
  end

  // request bus
  assign req_o.addr        = {bundle_i.alu_data[31:2], 2'b00};  // word address
  assign req_o.addr_valid  = req_ok & ~ready_i;  // drops in ready cycle
  assign req_o.write_valid = req_ok & is_store;  // kept through ready for commit
  assign req_o.mask        = is_store ? (base_mask << offset) : base_mask;
  assign req_o.size        = size;
  assign req_o.wdata       = store_data << {offset, 3'b000};  // into its lane

  // the request level is the stall
  assign stall_o = req_o.addr_valid;

  // load lane extract + extend
  lsu_ext i_lsu_ext (
    .data_i   (rdata_i),
    .offset_i (offset),
    .size_i   (size),
    .signed_i (is_signed),
    .data_o   (load_data)
  );

  assign misalign_trap = mem_pkg::trap_t'(misalign) << mem_pkg::TRAP_MISALIGN;

  always_comb begin
    if (misalign) begin
      mem_data = '0;
    end else if (is_load) begin
      mem_data = load_data;
    end else if (is_store) begin
      mem_data = '0;  // stores write nothing back
    end else begin
      mem_data = bundle_i.alu_data;
    end
  end

  // writeback bundle
  assign wb_o.inst_addr = bundle_i.inst_addr;
  assign wb_o.inst_data = bundle_i.inst_data;
  assign wb_o.rd_idx    = bundle_i.rd_idx;
  assign wb_o.mem_data  = mem_data;
  assign wb_o.trap      = bundle_i.trap | misalign_trap;  // incoming bits kept

endmodule

`default_nettype wire

// File: verilog/mem_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top (
  input  wire             clk,
  input  wire             reset_i,
  input  wire             ex_valid_i,
  input  mem_pkg::exmem_t ex_bundle_i,
  output logic            stall_o,
  output logic            wb_valid_o,
  output mem_pkg::memwb_t wb_bundle_o
);

  // ex/mem -> stage
  logic               exmem_valid;
  mem_pkg::exmem_t    exmem_bundle;

  // stage <-> memory
  mem_pkg::dmem_req_t dmem_req;
  logic               dmem_ready;
  mem_pkg::xlen_t     dmem_rdata;

  // stage -> mem/wb, plus stall back to both regs
  mem_pkg::memwb_t    stage_wb;
  logic               mem_stall;

  exmem_reg i_exmem_reg (
    .clk      (clk),
    .reset_i  (reset_i),
    .stall_i  (mem_stall),
    .valid_i  (ex_valid_i),
    .bundle_i (ex_bundle_i),
    .valid_o  (exmem_valid),
    .bundle_o (exmem_bundle)
  );

  mem_stage i_mem_stage (
    .valid_i  (exmem_valid),
    .bundle_i (exmem_bundle),
    .ready_i  (dmem_ready),
    .rdata_i  (dmem_rdata),
    .req_o    (dmem_req),
    .stall_o  (mem_stall),
    .wb_o     (stage_wb)
  );

  dmem_sram i_dmem_sram (
    .clk     (clk),
    .reset_i (reset_i),
    .req_i   (dmem_req),
    .ready_o (dmem_ready),
    .rdata_o (dmem_rdata)
  );

  memwb_reg i_memwb_reg (
    .clk      (clk),
    .reset_i  (reset_i),
    .stall_i  (mem_stall),
    .valid_i  (exmem_valid),
    .bundle_i (stage_wb),
    .valid_o  (wb_valid_o),
    .bundle_o (wb_bundle_o)
  );

  assign stall_o = mem_stall;  // source holds input while high

endmodule

`default_nettype wire

// File: verilog/memwb_reg.sv
`timescale 1ns/1ps
`default_nettype none

module memwb_reg (
  input  wire             clk,
  input  wire             reset_i,
  input  wire             stall_i,
  input  wire             valid_i,
  input  mem_pkg::memwb_t bundle_i,
  output logic            valid_o,
  output mem_pkg::memwb_t bundle_o
);

  logic            valid_q;
  mem_pkg::memwb_t bundle_q;

  // bubble while the stage waits, so each instr shows once
  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i & ~stall_i;
    end
  end

  // payload only updated on real completion
  always_ff @(posedge clk) begin
    if (!stall_i) begin
      bundle_q <= bundle_i;
    end
  end

  assign valid_o  = valid_q;
  assign bundle_o = bundle_q;

endmodule

`default_nettype wire
